/* instruction_cache.f */
+incdir+include
verilog/icache_pkg.sv
verilog/icache_array_if.sv
verilog/icache_ctrl.sv
verilog/icache_tag_store.sv
verilog/icache_data_store.sv
verilog/instruction_cache.sv
verif/tb_instruction_cache.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the instruction cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_instruction_cache \
    -f instruction_cache.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build returned an error"
    exit 1
fi

./obj_dir/Vtb_instruction_cache > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulator exited with status $run_status"
    exit 1
fi

if grep -q "^Simulation passed$" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

/* include/tb_icache_util.svh */
// ############################
// LFSR, reference cache model
// Typed compare tasks
// ############################

`ifndef TB_ICACHE_UTIL_SVH
`define TB_ICACHE_UTIL_SVH

// Galois LFSR, x^32 + x^31 + x^29 + x + 1
logic [31:0] lfsr_state;

function automatic logic lfsr_step();
    logic out_bit;
    out_bit = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out_bit) begin
        lfsr_state = lfsr_state ^ 32'hD000_0001;
    end
    return out_bit;
endfunction

// One step per bit, first bit ends up highest
function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] value;
    value = '0;
    for (int unsigned i = 0; i < n; i++) begin
        value = {value[30:0], lfsr_step()};
    end
    return value;
endfunction

// ############################
// Reference model
// ############################

logic [NumCachelines-1:0] model_valid;
cache_tag_t               model_tag [NumCachelines];
// Lines that were valid when a flush ran
logic [NumCachelines-1:0] model_lost;

// PC is {tag, index, word offset}
function automatic cache_index_t pc_index(input pc_t pc);
    return pc[LineWordBits +: IndexBits];
endfunction

function automatic cache_tag_t pc_tag(input pc_t pc);
    return pc[PcWidth-1 -: TagBits];
endfunction

function automatic logic model_hit(input pc_t pc);
    return model_valid[pc_index(pc)] && (model_tag[pc_index(pc)] == pc_tag(pc));
endfunction

// Would have hit if no flush had run
function automatic logic model_refetch(input pc_t pc);
    return model_lost[pc_index(pc)] && (model_tag[pc_index(pc)] == pc_tag(pc));
endfunction

task automatic model_refill(input pc_t pc);
    model_valid[pc_index(pc)] = 1'b1;
    model_lost[pc_index(pc)]  = 1'b0;
    model_tag[pc_index(pc)]   = pc_tag(pc);
endtask

// Tags survive, valid bits do not
task automatic model_flush();
    model_lost  = model_lost | model_valid;
    model_valid = '0;
endtask

// ############################
// Compare tasks
// ############################

task automatic report_mismatch(input string what, input string got, input string exp);
    stop_with_failure($sformatf("MISMATCH at time %0t: %s is %s, expected %s",
                                $time, what, got, exp));
endtask

task automatic check_event(input string what, input logic got, input logic exp);
    if (got !== exp)
        report_mismatch(what, $sformatf("%b", got), $sformatf("%b", exp));
endtask

task automatic check_pc(input string what, input pc_t got, input pc_t exp);
    if (got !== exp)
        report_mismatch(what, $sformatf("%h", got), $sformatf("%h", exp));
endtask

task automatic check_mask(input string what, input act_mask_t got, input act_mask_t exp);
    if (got !== exp)
        report_mismatch(what, $sformatf("%h", got), $sformatf("%h", exp));
endtask

task automatic check_wid(input string what, input wid_t got, input wid_t exp);
    if (got !== exp)
        report_mismatch(what, $sformatf("%0d", got), $sformatf("%0d", exp));
endtask

task automatic check_subwarp(input string what, input subwarp_id_t got, input subwarp_id_t exp);
    if (got !== exp)
        report_mismatch(what, $sformatf("%0d", got), $sformatf("%0d", exp));
endtask

task automatic check_inst(input string what, input enc_inst_t got, input enc_inst_t exp);
    if (got !== exp)
        report_mismatch(what, $sformatf("%h", got), $sformatf("%h", exp));
endtask

task automatic check_line_addr(input string what, input line_addr_t got, input line_addr_t exp);
    if (got !== exp)
        report_mismatch(what, $sformatf("%h", got), $sformatf("%h", exp));
endtask

`endif

/* verif/tb_instruction_cache.sv */
// ############################
// Instruction cache testbench
// Random fetch, memory, decoder traffic
// ############################

module tb_instruction_cache;
    import icache_pkg::*;

    localparam int unsigned NumDeliveries = 400;
    localparam int unsigned MaxCycles     = 40000;
    localparam int unsigned ReqTimeout    = 200;

    typedef struct packed {
        pc_t         pc;
        act_mask_t   mask;
        wid_t        wid;
        subwarp_id_t swid;
    } fetch_req_t;

    // Where the request in flight stands
    typedef enum logic [1:0] {PhaseIdle, PhaseMiss, PhaseMem, PhaseOut} phase_e;

    logic        clk_i, rst_ni, flush_i;
    logic        fe_valid_i, ic_ready_o, dec_ready_i, ic_valid_o;
    logic        mem_ready_i, mem_req_o, mem_valid_i;
    pc_t         fe_pc_i, ic_pc_o;
    act_mask_t   fe_act_mask_i, ic_act_mask_o;
    wid_t        fe_warp_id_i, ic_warp_id_o;
    subwarp_id_t fe_subwarp_id_i, ic_subwarp_id_o;
    enc_inst_t   ic_inst_o;
    line_addr_t  mem_addr_o;
    cache_line_t mem_data_i;

    phase_e      phase;
    fetch_req_t  exp_q [$];
    logic        flush_pend, fe_taken;
    int unsigned delivered, cycles, age, hits, misses, flushes, refetches;
    // Memory responder
    logic        mem_busy;
    int unsigned mem_wait;
    line_addr_t  mem_line;
    enc_inst_t   word_table [128];

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    `include "tb_icache_util.svh"

    instruction_cache i_dut (.*);

    always #20 clk_i = ~clk_i;

    // Memory contents, every address bit folded into the word
    function automatic enc_inst_t table_word(input line_addr_t la, input word_offset_t off);
        logic [31:0] addr;
        enc_inst_t   word;
        addr = {1'b0, la};
        word = word_table[{la[5:0], off}];
        for (int i = 0; i < 32; i += 4) begin
            word = word ^ addr[i +: 4];
        end
        return word;
    endfunction

    function automatic cache_line_t build_line(input line_addr_t la);
        return {table_word(la, 1'b1), table_word(la, 1'b0)};
    endfunction

    // Three tags over all indices, so lines conflict
    function automatic pc_t random_pc();
        cache_tag_t tag;
        case (rand_bits(4) % 3)
            0: tag = 29'h0ABC_1230;
            1: tag = 29'h1357_9BD1;
            default: tag = 29'h0246_8ACE;
        endcase
        return {tag, cache_index_t'(rand_bits(IndexBits)),
                word_offset_t'(rand_bits(LineWordBits))};
    endfunction

    task automatic drive_inputs();
        // Request held until taken
        if (fe_taken || !fe_valid_i) begin
            fe_taken        = 1'b0;
            fe_valid_i      = (rand_bits(2) != 0);
            fe_pc_i         = random_pc();
            fe_act_mask_i   = act_mask_t'(rand_bits(WarpWidth));
            fe_warp_id_i    = wid_t'(rand_bits(3));
            fe_subwarp_id_i = subwarp_id_t'(rand_bits(5));
        end
        dec_ready_i = lfsr_step();
        mem_ready_i = lfsr_step();
        flush_i     = (rand_bits(6) == 0);
        // One-cycle response strobe after the drawn latency
        mem_valid_i = 1'b0;
        if (mem_busy) begin
            if (mem_wait == 0) begin
                mem_valid_i = 1'b1;
                mem_data_i  = build_line(mem_line);
                mem_busy    = 1'b0;
            end else begin
                mem_wait--;
            end
        end
    endtask

    // Stalled cycles compare against the same entry, so outputs must hold
    task automatic check_outputs();
        fetch_req_t cur;
        cur = (exp_q.size() != 0) ? exp_q[0] : '0;
        check_event("ic_ready_o", ic_ready_o,
                    ((phase == PhaseIdle) || ((phase == PhaseOut) && dec_ready_i)) && !flush_pend);
        check_event("ic_valid_o", ic_valid_o, phase == PhaseOut);
        check_event("mem_req_o", mem_req_o, phase == PhaseMiss);
        if (phase == PhaseMiss) begin
            check_line_addr("mem_addr_o", mem_addr_o, cur.pc[PcWidth-1:LineWordBits]);
        end
        if (phase == PhaseOut) begin
            check_pc("ic_pc_o", ic_pc_o, cur.pc);
            check_mask("ic_act_mask_o", ic_act_mask_o, cur.mask);
            check_wid("ic_warp_id_o", ic_warp_id_o, cur.wid);
            check_subwarp("ic_subwarp_id_o", ic_subwarp_id_o, cur.swid);
            check_inst("ic_inst_o", ic_inst_o,
                       table_word(cur.pc[PcWidth-1:LineWordBits], cur.pc[LineWordBits-1:0]));
        end
    endtask

    // Advance the model to what the coming edge does
    task automatic update_model();
        fetch_req_t head, req;
        logic       flush_now;
        head      = (exp_q.size() != 0) ? exp_q[0] : '0;
        flush_now = flush_pend && ((phase == PhaseIdle) || ((phase == PhaseOut) && dec_ready_i));
        if (phase != PhaseIdle) begin
            age++;
            if (age > ReqTimeout) begin
                stop_with_failure("Timeout: accepted request was never delivered");
            end
        end
        case (phase)
            PhaseMiss: begin
                if (mem_ready_i) begin
                    phase    = PhaseMem;
                    mem_busy = 1'b1;
                    mem_wait = rand_bits(3);
                    mem_line = head.pc[PcWidth-1:LineWordBits];
                end
            end
            PhaseMem: begin
                if (mem_valid_i) begin
                    model_refill(head.pc);
                    phase = PhaseOut;
                end
            end
            PhaseOut: begin
                if (dec_ready_i) begin
                    void'(exp_q.pop_front());
                    delivered++;
                    phase = PhaseIdle;
                end
            end
            default: ;
        endcase
        if (flush_now) begin
            model_flush();
            flushes++;
        end
        flush_pend = !flush_now && (flush_pend || flush_i);
        // Acceptance, hit or miss decided by the model
        if (fe_valid_i && ic_ready_o) begin
            req = '{fe_pc_i, fe_act_mask_i, fe_warp_id_i, fe_subwarp_id_i};
            exp_q.push_back(req);
            age      = 0;
            fe_taken = 1'b1;
            if (model_hit(fe_pc_i)) begin
                phase = PhaseOut;
                hits++;
            end else begin
                phase = PhaseMiss;
                misses++;
                if (model_refetch(fe_pc_i)) begin
                    refetches++;
                end
            end
        end
    endtask

    initial begin
        lfsr_state  = 32'd34;
        clk_i       = 1'b0;
        rst_ni      = 1'b0;
        flush_i     = 1'b0;
        fe_valid_i  = 1'b0;
        fe_pc_i     = '0;
        fe_act_mask_i   = '0;
        fe_warp_id_i    = '0;
        fe_subwarp_id_i = '0;
        dec_ready_i = 1'b0;
        mem_ready_i = 1'b0;
        mem_valid_i = 1'b0;
        mem_data_i  = '0;
        phase       = PhaseIdle;
        flush_pend  = 1'b0;
        fe_taken    = 1'b0;
        mem_busy    = 1'b0;
        mem_wait    = 0;
        mem_line    = '0;
        delivered   = 0;
        cycles      = 0;
        age         = 0;
        hits        = 0;
        misses      = 0;
        flushes     = 0;
        refetches   = 0;
        model_valid = '0;
        model_lost  = '0;
        for (int i = 0; i < 128; i++) begin
            word_table[i] = enc_inst_t'(rand_bits(EncInstWidth));
        end
        // Reset for 4 cycles, released on a falling edge
        repeat (4) @(negedge clk_i);
        rst_ni = 1'b1;
        #1;
        check_event("ic_valid_o after reset", ic_valid_o, 1'b0);
        check_event("mem_req_o after reset", mem_req_o, 1'b0);
        while (delivered < NumDeliveries) begin
            if (cycles >= MaxCycles) begin
                stop_with_failure("Timeout: too few instructions delivered");
            end
            @(negedge clk_i);
            drive_inputs();
            #1;
            check_outputs();
            update_model();
            cycles++;
        end
        if ((hits == 0) || (misses == 0) || (flushes == 0) || (refetches == 0)) begin
            stop_with_failure("Coverage hole: no hit, miss, flush or miss after a flush");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule : tb_instruction_cache

/* verilog/instruction_cache.sv */
// ############################
// Instruction cache top level
// Controller and both stores
// ############################

module instruction_cache (
    // Clock and reset
    input  logic                     clk_i,
    input  logic                     rst_ni,

    // Invalidate all lines
    input  logic                     flush_i,

    // Memory request
    input  logic                     mem_ready_i,
    output logic                     mem_req_o,
    output icache_pkg::line_addr_t   mem_addr_o,

    // Memory response
    input  logic                     mem_valid_i,
    input  icache_pkg::cache_line_t  mem_data_i,

    // From fetcher
    output logic                     ic_ready_o,
    input  logic                     fe_valid_i,
    input  icache_pkg::pc_t          fe_pc_i,
    input  icache_pkg::act_mask_t    fe_act_mask_i,
    input  icache_pkg::wid_t         fe_warp_id_i,
    input  icache_pkg::subwarp_id_t  fe_subwarp_id_i,

    // To decoder
    input  logic                     dec_ready_i,
    output logic                     ic_valid_o,
    output icache_pkg::pc_t          ic_pc_o,
    output icache_pkg::act_mask_t    ic_act_mask_o,
    output icache_pkg::wid_t         ic_warp_id_o,
    output icache_pkg::enc_inst_t    ic_inst_o,
    output icache_pkg::subwarp_id_t  ic_subwarp_id_o
);

    // Commands and results between controller and arrays
    icache_array_if arr_if ();

    icache_ctrl i_ctrl (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .flush_i         (flush_i),
        .fe_valid_i      (fe_valid_i),
        .fe_pc_i         (fe_pc_i),
        .fe_act_mask_i   (fe_act_mask_i),
        .fe_warp_id_i    (fe_warp_id_i),
        .fe_subwarp_id_i (fe_subwarp_id_i),
        .ic_ready_o      (ic_ready_o),
        .dec_ready_i     (dec_ready_i),
        .ic_valid_o      (ic_valid_o),
        .ic_pc_o         (ic_pc_o),
        .ic_act_mask_o   (ic_act_mask_o),
        .ic_warp_id_o    (ic_warp_id_o),
        .ic_subwarp_id_o (ic_subwarp_id_o),
        .mem_ready_i     (mem_ready_i),
        .mem_req_o       (mem_req_o),
        .mem_addr_o      (mem_addr_o),
        .mem_valid_i     (mem_valid_i),
        .arr             (arr_if.ctrl)
    );

    icache_tag_store i_tag_store (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .arr    (arr_if.tag)
    );

    // Response line goes straight into the data store
    icache_data_store i_data_store (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .mem_data_i (mem_data_i),
        .arr        (arr_if.data)
    );

    // Selected word to the decoder
    assign ic_inst_o = arr_if.inst;

endmodule : instruction_cache

/* verilog/icache_data_store.sv */
// ############################
// Data store
// Line array, refill buffer, word select
// ############################

module icache_data_store (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  icache_pkg::cache_line_t mem_data_i,
    icache_array_if.data            arr
);
    import icache_pkg::*;

    cache_line_t line_mem [NumCachelines];

    // Array read data, one cycle latency
    cache_line_t rd_line_q;
    // Last refill line
    cache_line_t refill_buf_q;
    // Set when the latest operation was a refill
    logic        refill_mark_q;

    cache_line_t sel_line;

    // ############################
    // Line array
    // ############################

    always_ff @(posedge clk_i) begin
        if (arr.refill_o) begin
            line_mem[arr.index] <= mem_data_i;
            refill_buf_q        <= mem_data_i;
        end
        if (arr.lookup_o) begin
            rd_line_q <= line_mem[arr.index];
        end
    end

    // Refill and lookup never share a cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            refill_mark_q <= 1'b0;
        end else if (arr.refill_o) begin
            refill_mark_q <= 1'b1;
        end else if (arr.lookup_o) begin
            refill_mark_q <= 1'b0;
        end
    end

    // ############################
    // Word select
    // ############################

    // Buffered refill line or array read
    assign sel_line = refill_mark_q ? refill_buf_q : rd_line_q;
    // Word 0 in the low bits
    assign arr.inst = sel_line[arr.offset * EncInstWidth +: EncInstWidth];

endmodule : icache_data_store

/* verilog/icache_tag_store.sv */
// ############################
// Tag store
// Tags, valid bits, hit decision
// ############################

module icache_tag_store (
    input  logic        clk_i,
    input  logic        rst_ni,
    icache_array_if.tag arr
);
    import icache_pkg::*;

    // One tag and one valid bit per line
    cache_tag_t               tag_mem [NumCachelines];
    logic [NumCachelines-1:0] valid_q;

    // Registered read port
    cache_tag_t rd_tag_q;
    logic       rd_valid_q;

    // ############################
    // Tag array
    // ############################

    always_ff @(posedge clk_i) begin
        if (arr.refill_o) begin
            tag_mem[arr.index] <= arr.req_tag;
        end
    end

    // Tag read, one cycle latency
    always_ff @(posedge clk_i) begin
        if (arr.lookup_o) begin
            rd_tag_q <= tag_mem[arr.index];
        end
    end

    // ############################
    // Valid bits
    // ############################

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q    <= '0;
            rd_valid_q <= 1'b0;
        end else begin
            // Bulk invalidate in a single cycle
            if (arr.invalidate) begin
                valid_q <= '0;
            end else if (arr.refill_o) begin
                valid_q[arr.index] <= 1'b1;
            end
            if (arr.lookup_o) begin
                rd_valid_q <= valid_q[arr.index];
            end
        end
    end

    // Compare against the held request tag
    assign arr.hit = rd_valid_q && (rd_tag_q == arr.req_tag);

endmodule : icache_tag_store

/* verilog/icache_ctrl.sv */
// ############################
// Instruction cache controller
// FSM, pending flush, active request
// ############################

module icache_ctrl (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    // Fetcher side
    input  logic                     fe_valid_i,
    input  icache_pkg::pc_t          fe_pc_i,
    input  icache_pkg::act_mask_t    fe_act_mask_i,
    input  icache_pkg::wid_t         fe_warp_id_i,
    input  icache_pkg::subwarp_id_t  fe_subwarp_id_i,
    output logic                     ic_ready_o,
    // Decoder side
    input  logic                     dec_ready_i,
    output logic                     ic_valid_o,
    output icache_pkg::pc_t          ic_pc_o,
    output icache_pkg::act_mask_t    ic_act_mask_o,
    output icache_pkg::wid_t         ic_warp_id_o,
    output icache_pkg::subwarp_id_t  ic_subwarp_id_o,
    // Memory side
    input  logic                     mem_ready_i,
    output logic                     mem_req_o,
    output icache_pkg::line_addr_t   mem_addr_o,
    input  logic                     mem_valid_i,
    // Array commands
    icache_array_if.ctrl             arr
);
    import icache_pkg::*;

    typedef enum logic [1:0] {
        Idle           = 2'd0,
        HandleInstr    = 2'd1,
        WaitForMem     = 2'd2,
        WaitForDecoder = 2'd3
    } state_e;

    state_e state_q, state_d;
    logic   flush_q, flush_d;

    // Active request
    pc_t         req_pc_q;
    act_mask_t   req_mask_q;
    wid_t        req_wid_q;
    subwarp_id_t req_swid_q;

    logic accept;
    logic out_take;
    logic flush_exec;
    logic cache_free;

    // ############################
    // Handshakes
    // ############################

    // Output valid on a hit or once refill data is buffered
    assign ic_valid_o = ((state_q == HandleInstr) && arr.hit) ||
                        (state_q == WaitForDecoder);
    assign out_take   = ic_valid_o && dec_ready_i;

    // Cache can take work when idle or when the output leaves
    assign cache_free = (state_q == Idle) || out_take;
    // Pending flush wins over a new request
    assign flush_exec = cache_free && flush_q;
    assign ic_ready_o = cache_free && !flush_q;
    assign accept     = ic_ready_o && fe_valid_i;

    // Miss keeps the request up until memory takes it
    assign mem_req_o  = (state_q == HandleInstr) && !arr.hit;
    assign mem_addr_o = mem_req_o ? req_pc_q[PcWidth-1:LineWordBits] : '0;

    // Held fields read zero while nothing is presented
    assign ic_pc_o         = ic_valid_o ? req_pc_q   : '0;
    assign ic_act_mask_o   = ic_valid_o ? req_mask_q : '0;
    assign ic_warp_id_o    = ic_valid_o ? req_wid_q  : '0;
    assign ic_subwarp_id_o = ic_valid_o ? req_swid_q : '0;

    // ############################
    // Array commands
    // ############################

    assign arr.lookup_o   = accept;
    assign arr.refill_o   = (state_q == WaitForMem) && mem_valid_i;
    // Lookup uses the incoming PC and refill the held one
    assign arr.index      = accept ? fe_pc_i[LineWordBits +: IndexBits]
                                   : req_pc_q[LineWordBits +: IndexBits];
    assign arr.req_tag    = req_pc_q[PcWidth-1 -: TagBits];
    assign arr.offset     = req_pc_q[LineWordBits-1:0];
    assign arr.invalidate = flush_exec;

    // ############################
    // Next state
    // ############################

    always_comb begin
        state_d = state_q;
        case (state_q)
            Idle: begin
                if (accept) begin
                    state_d = HandleInstr;
                end
            end
            HandleInstr: begin
                if (arr.hit) begin
                    // Back to back hit keeps us here
                    if (out_take) begin
                        state_d = accept ? HandleInstr : Idle;
                    end
                end else if (mem_ready_i) begin
                    state_d = WaitForMem;
                end
            end
            WaitForMem: begin
                // Latency is open ended
                if (mem_valid_i) begin
                    state_d = WaitForDecoder;
                end
            end
            WaitForDecoder: begin
                if (out_take) begin
                    state_d = accept ? HandleInstr : Idle;
                end
            end
            default: state_d = Idle;
        endcase
    end

    // Remember a flush strobe until it can run
    assign flush_d = flush_exec ? 1'b0 : (flush_q || flush_i);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= Idle;
            flush_q <= 1'b0;
        end else begin
            state_q <= state_d;
            flush_q <= flush_d;
        end
    end

    // Capture request fields at acceptance
    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_pc_q   <= fe_pc_i;
            req_mask_q <= fe_act_mask_i;
            req_wid_q  <= fe_warp_id_i;
            req_swid_q <= fe_subwarp_id_i;
        end
    end

endmodule : icache_ctrl

/* verilog/icache_array_if.sv */
// ############################
// Array command interface
// Controller to tag and data stores
// ############################

interface icache_array_if;
    import icache_pkg::*;

    // Read both arrays at index
    logic lookup_o;
    // Write both arrays at index
    logic refill_o;
    cache_index_t index;
    // Active request tag for the write and the hit compare
    cache_tag_t req_tag;
    // Word offset of the active request
    word_offset_t offset;
    // Clear every valid bit
    logic invalidate;

    // Results one cycle after a lookup
    logic hit;
    enc_inst_t inst;

    modport ctrl (
        output lookup_o, refill_o, index, req_tag, offset, invalidate,
        input  hit
    );

    modport tag (
        input  lookup_o, refill_o, index, req_tag, invalidate,
        output hit
    );

    modport data (
        input  lookup_o, refill_o, index, offset,
        output inst
    );

endinterface : icache_array_if

/* verilog/icache_pkg.sv */
// ############################
// Instruction cache package
// Geometry constants and vector types
// ############################

package icache_pkg;

    // ############################
    // Core and warp geometry
    // ############################

    // Program counter width
    localparam int unsigned PcWidth = 32;
    // Threads per warp
    localparam int unsigned WarpWidth = 32;
    // Warps per compute unit
    localparam int unsigned NumWarps = 8;
    // Encoded instruction width
    localparam int unsigned EncInstWidth = 4;

    // ############################
    // Cache geometry
    // ############################

    // Word offset bits, two words per line
    localparam int unsigned LineWordBits = 1;
    localparam int unsigned NumCachelines = 4;

    // PC = {tag, index, word offset}
    localparam int unsigned IndexBits = $clog2(NumCachelines);
    localparam int unsigned TagBits = PcWidth - IndexBits - LineWordBits;
    localparam int unsigned LineWidth = (1 << LineWordBits) * EncInstWidth;

    // Derived field widths
    localparam int unsigned WidWidth = $clog2(NumWarps);
    localparam int unsigned SubwarpIdWidth = $clog2(WarpWidth);
    localparam int unsigned LineAddrWidth = PcWidth - LineWordBits;

    // Request fields
    typedef logic [PcWidth-1:0] pc_t;
    typedef logic [WarpWidth-1:0] act_mask_t;
    typedef logic [WidWidth-1:0] wid_t;
    typedef logic [SubwarpIdWidth-1:0] subwarp_id_t;
    typedef logic [EncInstWidth-1:0] enc_inst_t;

    // Cache storage, word 0 sits in the low bits of a line
    typedef logic [LineWidth-1:0] cache_line_t;
    typedef logic [LineAddrWidth-1:0] line_addr_t;
    typedef logic [TagBits-1:0] cache_tag_t;
    typedef logic [IndexBits-1:0] cache_index_t;
    typedef logic [LineWordBits-1:0] word_offset_t;

endpackage : icache_pkg
